//--- common/seq_isa_pkg.sv
// ***************************************************************************
// Sequencer instruction set
// Opcodes, instruction word layout and address widths
// ***************************************************************************
`default_nettype none

package seq_isa_pkg;

  localparam int SLOT_ADDR_BITS = 16; // Slot address field in an instruction
  localparam int INST_ADDR_BITS = 16; // Instruction pointer

  // Only the opcodes this sequencer executes
  typedef enum logic [7:0] {
    NOOP_WAIT      = 8'h00,
    COPY_REG       = 8'h01,
    SEND_INTERRUPT = 8'h02
  } code_t;

  // 40 bit instruction word, code in the top byte
  typedef struct packed {
    code_t                     code;
    logic [SLOT_ADDR_BITS-1:0] a; // Source slot
    logic [SLOT_ADDR_BITS-1:0] b; // Destination slot or interrupt index
  } inst_t;

endpackage

`default_nettype wire

//--- common/slot_pkg.sv
// ***************************************************************************
// Slot data definitions
// Point types, slot word, slot counts per type and the interrupt packet
// layout (index queue entry, header beat, queued slot payload)
// ***************************************************************************
`default_nettype none

package slot_pkg;

  localparam int SLOT_BITS      = 96;
  localparam int TX_BITS        = 32;
  localparam int BEATS_PER_SLOT = SLOT_BITS / TX_BITS;

  typedef enum logic [2:0] {
    SCALAR = 3'd0,
    FE     = 3'd1,
    FE2    = 3'd2,
    FP_AF  = 3'd3,
    FP_JB  = 3'd4,
    FP2_AF = 3'd5,
    FP2_JB = 3'd6
  } point_type_t;

  typedef struct packed {
    point_type_t          pt;
    logic [SLOT_BITS-1:0] dat;
  } slot_t;

  // Number of consecutive slots one stored value occupies
  function automatic logic [7:0] slot_count(point_type_t pt);
    case (pt)
      FE2, FP_AF: return 8'd2;
      FP_JB:      return 8'd3;
      FP2_AF:     return 8'd4;
      FP2_JB:     return 8'd6;
      default:    return 8'd1; // SCALAR, FE
    endcase
  endfunction

  typedef struct packed {
    point_type_t pt;
    logic [15:0] idx;
  } intr_idx_t;

  // Header beat, type in the low bits
  typedef struct packed {
    logic [4:0]  rsvd;
    logic [7:0]  cnt;
    logic [15:0] idx;
    point_type_t pt;
  } intr_hdr_t;

  typedef struct packed {
    logic                 last; // Final slot of the packet
    logic [SLOT_BITS-1:0] dat;
  } slot_beat_t;

endpackage

`default_nettype wire

//--- hdl/slot_ram.sv
// ***************************************************************************
// Dual-port RAM, write-first on both ports
// One-cycle registered read, word type set by the instance
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module slot_ram #(
  parameter int  DEPTH  = 1024,
  parameter type word_t = logic [7:0]
) (
  input  logic                     i_clk,
  input  logic                     i_a_we,
  input  logic [$clog2(DEPTH)-1:0] i_a_addr,
  input  word_t                    i_a_wdat,
  output word_t                    o_a_rdat,
  input  logic                     i_b_we,
  input  logic [$clog2(DEPTH)-1:0] i_b_addr,
  input  word_t                    i_b_wdat,
  output word_t                    o_b_rdat
);

  word_t mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_a_we) mem[i_a_addr] <= i_a_wdat;
    if (i_b_we) mem[i_b_addr] <= i_b_wdat; // Port B wins on a collision
  end

  always_ff @(posedge i_clk) begin
    o_a_rdat <= i_a_we ? i_a_wdat : mem[i_a_addr];
    o_b_rdat <= i_b_we ? i_b_wdat : mem[i_b_addr];
  end

endmodule

`default_nettype wire

//--- hdl/stream_fifo.sv
// ***************************************************************************
// Synchronous FIFO
// Circular buffer with fill count, head shown without a pop
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
  parameter int  DEPTH   = 8, // Power of two
  parameter type entry_t = logic [7:0]
) (
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_push,
  input  entry_t i_dat,
  input  logic   i_pop,
  output entry_t o_dat,
  output logic   o_val,
  output logic   o_space
);

  localparam int AW = $clog2(DEPTH);

  entry_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= i_dat;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW+1)'(i_push) - (AW+1)'(i_pop);
    end
  end

  assign o_dat   = mem[rd_ptr];
  assign o_val   = (count != '0);
  assign o_space = (count <= (AW+1)'(DEPTH - 2)); // Room for one push in flight

endmodule

`default_nettype wire

//--- sequencer/inst_sequencer.sv
// ***************************************************************************
// Instruction sequencer
// Fetches from the instruction RAM and executes COPY_REG and SEND_INTERRUPT
// against the slot RAM until a NOOP_WAIT is reached
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module inst_sequencer #(
  parameter int INST_DEPTH = 256,
  parameter int DATA_DEPTH = 1024
) (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_start_val,
  input  logic [seq_isa_pkg::INST_ADDR_BITS-1:0] i_start_pt,
  output logic [$clog2(INST_DEPTH)-1:0]         o_inst_addr,
  input  seq_isa_pkg::inst_t                    i_inst,
  output logic [$clog2(DATA_DEPTH)-1:0]         o_slot_addr,
  output logic                                  o_slot_we,
  output slot_pkg::slot_t                       o_slot_wdat,
  input  slot_pkg::slot_t                       i_slot,
  output logic                                  o_idx_push,
  output slot_pkg::intr_idx_t                   o_idx_dat,
  output logic                                  o_slot_push,
  output slot_pkg::slot_beat_t                  o_slot_dat,
  input  logic                                  i_slot_space,
  output logic                                  o_waiting
);

  localparam int IA = $clog2(INST_DEPTH);
  localparam int DA = $clog2(DATA_DEPTH);

  typedef enum logic [1:0] {S_WAIT, S_FETCH, S_COPY, S_SEND} state_t;

  state_t     state;
  logic [1:0] phase;  // Step within fetch or instruction
  logic       rd_ok;  // i_slot holds the word at o_slot_addr
  logic [7:0] remain; // Slots still to queue

  assign o_waiting = (state == S_WAIT);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= S_WAIT;
      phase       <= '0;
      rd_ok       <= 1'b0;
      remain      <= '0;
      o_inst_addr <= '0;
      o_slot_addr <= '0;
      o_slot_we   <= 1'b0;
      o_idx_push  <= 1'b0;
      o_slot_push <= 1'b0;
    end else begin
      o_slot_we   <= 1'b0; // Strobes last one cycle
      o_idx_push  <= 1'b0;
      o_slot_push <= 1'b0;
      phase       <= phase + 2'd1;
      case (state)
        S_WAIT: begin
          phase <= '0;
          if (i_start_val) begin
            o_inst_addr <= i_start_pt[IA-1:0];
            state       <= S_FETCH;
          end
        end
        S_FETCH: begin
          // Phase 1 has the instruction word on i_inst
          if (phase == 2'd1) begin
            phase       <= '0;
            o_slot_addr <= i_inst.a[DA-1:0];
            rd_ok       <= 1'b0;
            case (i_inst.code)
              seq_isa_pkg::COPY_REG:       state <= S_COPY;
              seq_isa_pkg::SEND_INTERRUPT: state <= S_SEND;
              default:                     state <= S_WAIT;
            endcase
          end
        end
        S_COPY: begin
          if (phase == 2'd1) begin
            o_slot_addr <= i_inst.b[DA-1:0];
            o_slot_we   <= 1'b1;
            o_slot_wdat <= i_slot;
          end else if (phase == 2'd2) begin
            phase       <= '0;
            o_inst_addr <= o_inst_addr + 1'b1;
            state       <= S_FETCH;
          end
        end
        S_SEND: begin
          rd_ok <= 1'b1; // Address held for a cycle, data valid next
          if (phase == 2'd1) begin
            o_idx_push <= 1'b1;
            o_idx_dat  <= '{pt: i_slot.pt, idx: i_inst.b};
            remain     <= slot_pkg::slot_count(i_slot.pt);
          end else if (phase == 2'd2) begin
            phase <= 2'd2;
            if (rd_ok && i_slot_space) begin
              o_slot_push <= 1'b1;
              o_slot_dat  <= '{last: (remain == 8'd1), dat: i_slot.dat};
              remain      <= remain - 8'd1;
              if (remain == 8'd1) begin
                phase       <= '0;
                o_inst_addr <= o_inst_addr + 1'b1;
                state       <= S_FETCH;
              end else begin
                o_slot_addr <= o_slot_addr + 1'b1;
                rd_ok       <= 1'b0;
              end
            end
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- interrupt/interrupt_tx.sv
// ***************************************************************************
// Interrupt transmitter
// Takes an index entry, sends a header beat, then narrows each queued slot
// to the stream width, low bits first, under valid/ready flow control
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module interrupt_tx (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_idx_val,
  input  slot_pkg::intr_idx_t          i_idx,
  output logic                         o_idx_pop,
  input  logic                         i_slot_val,
  input  slot_pkg::slot_beat_t         i_slot,
  output logic                         o_slot_pop,
  output logic                         o_tx_val,
  output logic [slot_pkg::TX_BITS-1:0] o_tx_dat,
  output logic                         o_tx_sop,
  output logic                         o_tx_eop,
  input  logic                         i_tx_rdy,
  output logic                         o_busy
);

  localparam int BW = $clog2(slot_pkg::BEATS_PER_SLOT);

  typedef enum logic {T_IDLE, T_DATA} state_t;

  state_t              state;
  logic [BW-1:0]       beat;      // Beat within the current slot
  logic                adv;       // Output register free this cycle
  logic                last_beat;
  slot_pkg::intr_hdr_t hdr;

  assign adv       = !o_tx_val || i_tx_rdy;
  assign last_beat = (beat == BW'(slot_pkg::BEATS_PER_SLOT - 1));

  // Pops take effect in the cycle the beat is loaded
  assign o_idx_pop  = (state == T_IDLE) && i_idx_val && adv;
  assign o_slot_pop = (state == T_DATA) && i_slot_val && adv && last_beat;
  assign o_busy     = (state != T_IDLE) || o_tx_val;

  always_comb begin
    hdr     = '0;
    hdr.pt  = i_idx.pt;
    hdr.idx = i_idx.idx;
    hdr.cnt = slot_pkg::slot_count(i_idx.pt);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= T_IDLE;
      beat     <= '0;
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
    end else if (adv) begin
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
      case (state)
        T_IDLE: begin
          if (i_idx_val) begin
            o_tx_val <= 1'b1;
            o_tx_sop <= 1'b1;
            o_tx_dat <= hdr;
            state    <= T_DATA;
          end
        end
        T_DATA: begin
          if (i_slot_val) begin
            o_tx_val <= 1'b1;
            o_tx_dat <= i_slot.dat[beat*slot_pkg::TX_BITS +: slot_pkg::TX_BITS];
            beat     <= last_beat ? '0 : beat + 1'b1;
            if (last_beat && i_slot.last) begin
              o_tx_eop <= 1'b1; // End of packet
              state    <= T_IDLE;
            end
          end
        end
        default: state <= T_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/slot_seq_top.sv
// ***************************************************************************
// Slot sequencer top level
// Host-loaded instruction and slot RAMs, the sequencer, the interrupt
// queues and the transmit stage
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module slot_seq_top #(
  parameter int INST_DEPTH = 256,
  parameter int DATA_DEPTH = 1024,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_inst_we,
  input  logic [$clog2(INST_DEPTH)-1:0]         i_inst_waddr,
  input  seq_isa_pkg::inst_t                    i_inst_wdat,
  input  logic                                  i_slot_we,
  input  logic [$clog2(DATA_DEPTH)-1:0]         i_slot_addr,
  input  slot_pkg::slot_t                       i_slot_wdat,
  output slot_pkg::slot_t                       o_slot_rdat,
  input  logic                                  i_start_val,
  input  logic [seq_isa_pkg::INST_ADDR_BITS-1:0] i_start_pt,
  output logic                                  o_idle,
  output logic                                  o_tx_val,
  output logic [slot_pkg::TX_BITS-1:0]          o_tx_dat,
  output logic                                  o_tx_sop,
  output logic                                  o_tx_eop,
  input  logic                                  i_tx_rdy
);

  logic [$clog2(INST_DEPTH)-1:0] inst_addr;
  seq_isa_pkg::inst_t            inst;
  logic [$clog2(DATA_DEPTH)-1:0] seq_slot_addr;
  logic                          seq_slot_we;
  slot_pkg::slot_t               seq_slot_wdat;
  slot_pkg::slot_t               seq_slot;
  logic                          idx_push, idx_pop, idx_val;
  slot_pkg::intr_idx_t           idx_in, idx_out;
  logic                          slot_push, slot_pop, slot_val, slot_space;
  slot_pkg::slot_beat_t          slot_in, slot_out;
  logic                          seq_waiting, tx_busy;

  assign o_idle = seq_waiting && !tx_busy && !idx_val && !slot_val;

  slot_ram #(.DEPTH(INST_DEPTH), .word_t(seq_isa_pkg::inst_t)) u_inst_ram (
    .i_clk, .i_a_we(i_inst_we), .i_a_addr(i_inst_waddr), .i_a_wdat(i_inst_wdat),
    .o_a_rdat(),
    .i_b_we(1'b0), .i_b_addr(inst_addr), .i_b_wdat('0), .o_b_rdat(inst)
  );

  slot_ram #(.DEPTH(DATA_DEPTH), .word_t(slot_pkg::slot_t)) u_data_ram (
    .i_clk, .i_a_we(i_slot_we), .i_a_addr(i_slot_addr), .i_a_wdat(i_slot_wdat),
    .o_a_rdat(o_slot_rdat),
    .i_b_we(seq_slot_we), .i_b_addr(seq_slot_addr), .i_b_wdat(seq_slot_wdat),
    .o_b_rdat(seq_slot)
  );

  inst_sequencer #(.INST_DEPTH(INST_DEPTH), .DATA_DEPTH(DATA_DEPTH)) u_sequencer (
    .i_clk, .i_rst, .i_start_val, .i_start_pt,
    .o_inst_addr(inst_addr), .i_inst(inst),
    .o_slot_addr(seq_slot_addr), .o_slot_we(seq_slot_we), .o_slot_wdat(seq_slot_wdat),
    .i_slot(seq_slot),
    .o_idx_push(idx_push), .o_idx_dat(idx_in),
    .o_slot_push(slot_push), .o_slot_dat(slot_in), .i_slot_space(slot_space),
    .o_waiting(seq_waiting)
  );

  // Index entry per packet
  stream_fifo #(.DEPTH(FIFO_DEPTH), .entry_t(slot_pkg::intr_idx_t)) u_idx_fifo (
    .i_clk, .i_rst, .i_push(idx_push), .i_dat(idx_in), .i_pop(idx_pop),
    .o_dat(idx_out), .o_val(idx_val), .o_space()
  );

  stream_fifo #(.DEPTH(FIFO_DEPTH), .entry_t(slot_pkg::slot_beat_t)) u_slot_fifo (
    .i_clk, .i_rst, .i_push(slot_push), .i_dat(slot_in), .i_pop(slot_pop),
    .o_dat(slot_out), .o_val(slot_val), .o_space(slot_space)
  );

  interrupt_tx u_interrupt_tx (
    .i_clk, .i_rst,
    .i_idx_val(idx_val), .i_idx(idx_out), .o_idx_pop(idx_pop),
    .i_slot_val(slot_val), .i_slot(slot_out), .o_slot_pop(slot_pop),
    .o_tx_val, .o_tx_dat, .o_tx_sop, .o_tx_eop, .i_tx_rdy,
    .o_busy(tx_busy)
  );

endmodule

`default_nettype wire

//--- dv/slot_seq_tb.sv
// ***************************************************************************
// Slot sequencer testbench
// LFSR-driven programs of COPY_REG and SEND_INTERRUPT, checked against a
// model of the slot memory and of the expected transmit beats
// ***************************************************************************
`timescale 1ns/100ps
`default_nettype none

module slot_seq_tb;

  localparam int INST_DEPTH = 256;
  localparam int DATA_DEPTH = 1024;

  logic                         i_clk;
  logic                         i_rst;
  logic                         i_inst_we;
  logic [7:0]                   i_inst_waddr;
  seq_isa_pkg::inst_t           i_inst_wdat;
  logic                         i_slot_we;
  logic [9:0]                   i_slot_addr;
  slot_pkg::slot_t              i_slot_wdat;
  slot_pkg::slot_t              o_slot_rdat;
  logic                         i_start_val;
  logic [15:0]                  i_start_pt;
  logic                         o_idle;
  logic                         o_tx_val;
  logic [slot_pkg::TX_BITS-1:0] o_tx_dat;
  logic                         o_tx_sop;
  logic                         o_tx_eop;
  logic                         i_tx_rdy;

  seq_isa_pkg::inst_t inst_model [INST_DEPTH];
  slot_pkg::slot_t    slot_model [DATA_DEPTH];
  logic [33:0]        beat_q [$];  // {sop, eop, data}
  logic [33:0]        exp_beat;
  logic [31:0]        lfsr = 32'hc6738eaa;
  string              test_name = "reset";

  slot_seq_top #(
    .INST_DEPTH(INST_DEPTH), .DATA_DEPTH(DATA_DEPTH), .FIFO_DEPTH(8)
  ) i_slot_seq_top (
    .i_clk, .i_rst, .i_inst_we, .i_inst_waddr, .i_inst_wdat,
    .i_slot_we, .i_slot_addr, .i_slot_wdat, .o_slot_rdat,
    .i_start_val, .i_start_pt, .o_idle,
    .o_tx_val, .o_tx_dat, .o_tx_sop, .o_tx_eop, .i_tx_rdy
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic slot_pkg::slot_t random_slot();
    slot_pkg::slot_t s;
    s.pt = slot_pkg::point_type_t'(3'(random_bits(3) % 7)); // Valid types only
    for (int w = 0; w < 3; w++) s.dat[w*32 +: 32] = random_bits(32);
    return s;
  endfunction

  // Slots per stored value
  function automatic int expected_count(logic [2:0] pt);
    case (pt)
      3'd2, 3'd3: return 2;
      3'd4:       return 3;
      3'd5:       return 4;
      3'd6:       return 6;
      default:    return 1;
    endcase
  endfunction

  function automatic seq_isa_pkg::inst_t make_inst(seq_isa_pkg::code_t code,
                                                   logic [15:0] a, logic [15:0] b);
    seq_isa_pkg::inst_t ins;
    ins.code = code;
    ins.a    = a;
    ins.b    = b;
    return ins;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act)
      stop_on_error($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                              test_name, what, exp, act));
  endtask

  task automatic check_slot(input string what, input slot_pkg::slot_t exp,
                            input slot_pkg::slot_t act);
    if (exp !== act)
      stop_on_error($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                              test_name, what, exp, act));
  endtask

  task automatic check_beat(input logic [slot_pkg::TX_BITS-1:0] exp_dat,
                            input logic exp_sop, input logic exp_eop,
                            input logic [slot_pkg::TX_BITS-1:0] act_dat,
                            input logic act_sop, input logic act_eop);
    if (exp_dat !== act_dat || exp_sop !== act_sop || exp_eop !== act_eop)
      stop_on_error($sformatf(
        "Mismatch in %s: expected dat=%h sop=%b eop=%b, actual dat=%h sop=%b eop=%b",
        test_name, exp_dat, exp_sop, exp_eop, act_dat, act_sop, act_eop));
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic write_inst(input int addr, input seq_isa_pkg::inst_t ins);
    i_inst_we        = 1'b1;
    i_inst_waddr     = 8'(addr);
    i_inst_wdat      = ins;
    inst_model[addr] = ins;
    next_cycle();
    i_inst_we = 1'b0;
  endtask

  task automatic write_copy(input int addr);
    logic [15:0] a;
    logic [15:0] b;
    a = 16'(random_bits(10));
    b = 16'(random_bits(10));
    write_inst(addr, make_inst(seq_isa_pkg::COPY_REG, a, b));
  endtask

  task automatic write_slot(input int addr, input slot_pkg::slot_t s);
    i_slot_we        = 1'b1;
    i_slot_addr      = 10'(addr);
    i_slot_wdat      = s;
    slot_model[addr] = s;
    next_cycle();
    i_slot_we = 1'b0;
  endtask

  task automatic read_slot(input int addr, output slot_pkg::slot_t s);
    i_slot_addr = 10'(addr);
    next_cycle();
    s = o_slot_rdat; // Registered one cycle after the address
  endtask

  task automatic compare_all_slots();
    slot_pkg::slot_t r;
    for (int i = 0; i < DATA_DEPTH; i++) begin
      read_slot(i, r);
      check_slot($sformatf("slot %0d", i), slot_model[i], r);
    end
  endtask

  // Executes the program on the model and queues the beats it should send
  task automatic model_run(input int start, output int n_inst);
    int                 addr;
    int                 a;
    int                 cnt;
    seq_isa_pkg::inst_t ins;
    slot_pkg::slot_t    s;
    addr   = start;
    n_inst = 0;
    forever begin
      ins    = inst_model[addr % INST_DEPTH];
      n_inst = n_inst + 1;
      if (ins.code == seq_isa_pkg::NOOP_WAIT || n_inst > INST_DEPTH) break;
      a = ins.a % DATA_DEPTH;
      if (ins.code == seq_isa_pkg::COPY_REG) begin
        slot_model[ins.b % DATA_DEPTH] = slot_model[a];
      end else begin
        s   = slot_model[a];
        cnt = expected_count(s.pt);
        beat_q.push_back({1'b1, 1'b0, 5'd0, 8'(cnt), ins.b, 3'(s.pt)}); // Header
        for (int k = 0; k < cnt; k++) begin
          s = slot_model[(a + k) % DATA_DEPTH];
          for (int w = 0; w < 3; w++)
            beat_q.push_back({1'b0, (k == cnt - 1 && w == 2), s.dat[w*32 +: 32]});
        end
      end
      addr = addr + 1;
    end
  endtask

  task automatic run_program(input int start, input logic random_rdy);
    int n_inst;
    int limit;
    int cycles;
    model_run(start, n_inst);
    limit       = 4 * (40 * n_inst + 8 * beat_q.size());
    cycles      = 0;
    i_start_val = 1'b1;
    i_start_pt  = 16'(start);
    next_cycle();
    i_start_val = 1'b0;
    while (!o_idle) begin
      i_tx_rdy = random_rdy ? 1'(random_bits(1)) : 1'b1;
      next_cycle();
      cycles++;
      if (cycles > limit)
        stop_on_error($sformatf("Timeout in %s: not idle after %0d cycles",
                                test_name, cycles));
    end
    i_tx_rdy = 1'b1;
    if (beat_q.size() != 0)
      stop_on_error($sformatf("In %s, %0d expected beats were never sent",
                              test_name, beat_q.size()));
  endtask

  // Beat transfers on the next edge when valid and ready are both high here
  always @(negedge i_clk) begin
    if (!i_rst && o_tx_val && i_tx_rdy) begin
      if (beat_q.size() == 0) begin
        stop_on_error($sformatf("In %s, a beat was sent with none expected: %h",
                                test_name, o_tx_dat));
      end else begin
        exp_beat = beat_q.pop_front();
        check_beat(exp_beat[31:0], exp_beat[33], exp_beat[32],
                   o_tx_dat, o_tx_sop, o_tx_eop);
      end
    end
  end

  initial begin
    slot_pkg::slot_t s;
    slot_pkg::slot_t r;
    int              base;
    logic [15:0]     idx;
    i_rst        = 1'b1;
    i_inst_we    = 1'b0;
    i_inst_waddr = '0;
    i_inst_wdat  = '0;
    i_slot_we    = 1'b0;
    i_slot_addr  = '0;
    i_slot_wdat  = '0;
    i_start_val  = 1'b0;
    i_start_pt   = '0;
    i_tx_rdy     = 1'b1;
    repeat (8) @(posedge i_clk);
    #1 i_rst = 1'b0;

    check_flag("o_tx_val", 1'b0, o_tx_val);
    check_flag("o_idle", 1'b1, o_idle);
    s = random_slot();
    write_slot(5, s);
    read_slot(5, r);
    check_slot("slot 5", s, r);

    test_name = "copy_program";
    for (int i = 0; i < DATA_DEPTH; i++) write_slot(i, random_slot()); // RAM not cleared
    for (int i = 0; i < 12; i++) write_copy(i);
    write_inst(12, make_inst(seq_isa_pkg::NOOP_WAIT, '0, '0));
    run_program(0, 1'b0);
    compare_all_slots();

    // One packet per point type
    test_name = "send_each_type";
    for (int t = 0; t < 7; t++) begin
      base = 600 + 8 * t;
      s    = random_slot();
      s.pt = slot_pkg::point_type_t'(3'(t));
      write_slot(base, s);
      idx = 16'(random_bits(16));
      write_inst(32 + t, make_inst(seq_isa_pkg::SEND_INTERRUPT, 16'(base), idx));
    end
    write_inst(39, make_inst(seq_isa_pkg::NOOP_WAIT, '0, '0));
    run_program(32, 1'b0);

    test_name = "send_backpressure";
    run_program(32, 1'b1);

    // Copies after the first NOOP_WAIT must not run
    test_name = "second_start";
    for (int i = 0; i < 4; i++) begin
      write_copy(64 + i);
      write_copy(69 + i);
    end
    write_inst(68, make_inst(seq_isa_pkg::NOOP_WAIT, '0, '0));
    write_inst(73, make_inst(seq_isa_pkg::NOOP_WAIT, '0, '0));
    run_program(64, 1'b1);
    compare_all_slots();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/seq_isa_pkg.sv
common/slot_pkg.sv
hdl/slot_ram.sv
hdl/stream_fifo.sv
sequencer/inst_sequencer.sv
interrupt/interrupt_tx.sv
hdl/slot_seq_top.sv
dv/slot_seq_tb.sv

//--- Bender.yml
package:
  name: slot_seq

sources:
  - common/seq_isa_pkg.sv
  - common/slot_pkg.sv
  - hdl/slot_ram.sv
  - hdl/stream_fifo.sv
  - sequencer/inst_sequencer.sv
  - interrupt/interrupt_tx.sv
  - hdl/slot_seq_top.sv
  - target: test
    files:
      - dv/slot_seq_tb.sv
